/* compile.f */
src/rs_pkg.sv
src/rs_dispatch.sv
src/rs_entry_array.sv
src/rs_issue_select.sv
src/rs_alu_top.sv
bench/rs_alu_chk.sv
bench/rs_alu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module rs_alu_tb -f compile.f -o rs_alu_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/rs_alu_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
    exit 0
else
    exit 1
fi

/* bench/rs_alu_tb.sv */
`timescale 1ns/1ps

module rs_alu_tb;
    import rs_pkg::*;

    localparam int          clk_period     = 8;
    localparam int          reset_cycles   = 5;
    localparam int          cycles_per_row = 20;
    localparam int          full_test      = 5;
    localparam logic [31:0] lfsr_taps      = 32'h8020_0003; // x^32+x^22+x^2+x+1

    typedef struct packed {
        int               test;
        logic             disp;
        logic [tag_w-1:0] rd;
        logic [tag_w-1:0] tag1;
        logic             v1;
        logic [tag_w-1:0] tag2;
        logic             v2;
        logic             bc;
        logic             bus;    // 0 alu, 1 load
        logic [tag_w-1:0] bc_tag;
        logic             iv;     // issue seen right after the edge applying this row
        logic [tag_w-1:0] exp_rd;
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        dispatch_valid;
    rs_ctrl_t    dispatch_ctrl;
    rs_src_t     dispatch_src1;
    rs_src_t     dispatch_src2;
    cdb_bus_t    cdb;
    logic        issue_valid;
    rs_issue_t   issue;
    logic        rs_full;

    row_t        tab[$];
    logic        table_ready = 1'b0;
    logic [31:0] lfsr = 32'd41;
    string       test_names[6] = '{"reset", "ready at dispatch", "alu wakeup",
                                   "load capture", "burst wakeup", "fill and drain"};

    // reference model
    logic        m_busy[rs_depth];
    rs_ctrl_t    m_ctrl[rs_depth];
    rs_src_t     m_src1[rs_depth];
    rs_src_t     m_src2[rs_depth];
    logic        exp_valid;
    rs_issue_t   exp_issue;
    logic        exp_full;

    int          n_errors = 0;
    int          n_checks = 0;
    int          n_tests = 0;
    int          test_errs = 0;
    int          n_disp = 0;
    int          n_issued = 0;
    logic        saw_full = 1'b0;

    always #(clk_period / 2) clk = ~clk;

    rs_alu_top UUT (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ctrl  (dispatch_ctrl),
        .dispatch_src1  (dispatch_src1),
        .dispatch_src2  (dispatch_src2),
        .cdb            (cdb),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .rs_full        (rs_full)
    );

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ lfsr_taps;
            end
            val = {val[30:0], b};
        end
        return val;
    endfunction

    // alu bus first, load bus only if alu misses
    function automatic rs_src_t wake_operand(input rs_src_t s, input cdb_bus_t b);
        rs_src_t r;
        r = s;
        if (!s.valid && b[0].valid && b[0].tag == s.tag) begin
            r.valid = 1'b1;
            r.data  = b[0].data;
        end else if (!s.valid && b[1].valid && b[1].tag == s.tag) begin
            r.valid = 1'b1;
            r.data  = b[1].data;
        end
        return r;
    endfunction

    task automatic add_row(input int test, input logic disp, input logic [7:0] rd,
                           input logic [7:0] t1, input logic v1, input logic [7:0] t2,
                           input logic v2, input logic bc, input logic bus,
                           input logic [7:0] bc_tag);
        tab.push_back('{test, disp, rd, t1, v1, t2, v2, bc, bus, bc_tag, 1'b0, 8'h00});
    endtask

    task automatic add_idle(input int test, input int n);
        for (int i = 0; i < n; i++) begin
            add_row(test, 1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 8'h00);
        end
    endtask

    // idle row where the entry with this rd must come out
    task automatic add_expect(input int test, input logic [7:0] rd);
        tab.push_back('{test, 1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 1'b0,
                        1'b0, 1'b0, 8'h00, 1'b1, rd});
    endtask

    task automatic add_bc(input int test, input logic bus, input logic [7:0] tag);
        add_row(test, 1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 1'b0, 1'b1, bus, tag);
    endtask

    task automatic build_table;
        add_idle(0, 2);
        add_row(1, 1'b1, 8'h11, 8'h00, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0, 8'h00);
        add_idle(1, 1);
        add_expect(1, 8'h11);
        add_idle(1, 1);
        add_row(2, 1'b1, 8'h12, 8'h20, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0, 8'h00);
        add_idle(2, 1);
        add_bc(2, 1'b0, 8'h21); // wrong tag, must keep waiting
        add_idle(2, 1);
        add_bc(2, 1'b0, 8'h20);
        add_idle(2, 1);
        add_expect(2, 8'h12);
        add_idle(2, 1);
        add_row(3, 1'b1, 8'h13, 8'h30, 1'b0, 8'h00, 1'b1, 1'b1, 1'b1, 8'h30);
        add_idle(3, 1);
        add_expect(3, 8'h13);
        add_idle(3, 1);
        for (int k = 0; k < 3; k++) begin
            add_row(4, 1'b1, 8'(8'h14 + k), 8'h40, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0, 8'h00);
        end
        add_idle(4, 1);
        add_bc(4, 1'b0, 8'h40);
        add_idle(4, 1);
        for (int k = 0; k < 3; k++) begin
            add_expect(4, 8'(8'h14 + k));
        end
        add_idle(4, 1);
        for (int k = 0; k < rs_depth; k++) begin
            add_row(5, 1'b1, 8'(8'h60 + k), 8'h50, 1'b0, 8'h51, 1'b0, 1'b0, 1'b0, 8'h00);
        end
        add_idle(5, 2);
        add_bc(5, 1'b0, 8'h50);
        add_bc(5, 1'b1, 8'h51); // second operand from the load bus
        add_idle(5, 1);
        for (int k = 0; k < rs_depth; k++) begin
            add_expect(5, 8'(8'h60 + k));
        end
        add_idle(5, 1);
    endtask

    task automatic drive_row(input row_t r);
        rs_ctrl_t   c;
        rs_src_t    s1;
        rs_src_t    s2;
        cdb_bus_t   b;
        logic [3:0] op_bits;
        c  = '0;
        s1 = '0;
        s2 = '0;
        b  = '0;
        if (r.disp) begin
            op_bits       = 4'(take_bits(4) % 32'd11);
            c.pc          = take_bits(32);
            c.rd          = r.rd;
            c.alu_op      = alu_op_e'(op_bits);
            c.funct3      = 3'(take_bits(3));
            c.imm         = take_bits(32);
            c.src1_is_pc  = 1'(take_bits(1));
            c.src2_is_imm = 1'(take_bits(1));
            s1.tag        = r.tag1;
            s1.valid      = r.v1;
            s1.data       = take_bits(32); // junk when waiting
            s2.tag        = r.tag2;
            s2.valid      = r.v2;
            s2.data       = take_bits(32);
        end
        if (r.bc) begin
            b[r.bus].valid = 1'b1;
            b[r.bus].tag   = r.bc_tag;
            b[r.bus].data  = take_bits(32);
        end
        dispatch_valid <= r.disp;
        dispatch_ctrl  <= c;
        dispatch_src1  <= s1;
        dispatch_src2  <= s2;
        cdb            <= b;
    endtask

    // one clock edge of the model, fed with what the DUT samples there
    task automatic model_step;
        int grant_slot;
        int free_slot;
        grant_slot = -1;
        free_slot  = -1;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (m_busy[i] && m_src1[i].valid && m_src2[i].valid) begin
                grant_slot = i;
            end
            if (!m_busy[i]) begin
                free_slot = i;
            end
        end
        exp_valid = (grant_slot >= 0);
        if (exp_valid) begin
            exp_issue.ctrl = m_ctrl[grant_slot];
            exp_issue.op1  = m_src1[grant_slot].data;
            exp_issue.op2  = m_src2[grant_slot].data;
            m_busy[grant_slot] = 1'b0;
        end
        for (int i = 0; i < rs_depth; i++) begin
            m_src1[i] = wake_operand(m_src1[i], cdb);
            m_src2[i] = wake_operand(m_src2[i], cdb);
        end
        if (dispatch_valid && free_slot >= 0) begin
            m_busy[free_slot] = 1'b1;
            m_ctrl[free_slot] = dispatch_ctrl;
            m_src1[free_slot] = wake_operand(dispatch_src1, cdb);
            m_src2[free_slot] = wake_operand(dispatch_src2, cdb);
            n_disp++;
        end
        exp_full = 1'b1;
        for (int i = 0; i < rs_depth; i++) begin
            if (!m_busy[i]) begin
                exp_full = 1'b0;
            end
        end
    endtask

    task automatic report_wrong_value(input string sig, input logic [127:0] got,
                                      input logic [127:0] exp);
        $display("mismatch at %0t: %s got %0h expected %0h", $time, sig, got, exp);
        n_errors++;
        test_errs++;
    endtask

    task automatic check_outputs(input row_t r);
        n_checks++;
        if (issue_valid !== r.iv) begin
            report_wrong_value("issue_valid", 128'(issue_valid), 128'(r.iv));
        end
        if (rs_full !== exp_full) begin
            report_wrong_value("rs_full", 128'(rs_full), 128'(exp_full));
        end
        if (r.iv && issue.ctrl.rd !== r.exp_rd) begin
            report_wrong_value("issue.ctrl.rd", 128'(issue.ctrl.rd), 128'(r.exp_rd));
        end
        if (r.iv && issue.ctrl !== exp_issue.ctrl) begin
            report_wrong_value("issue.ctrl", 128'(issue.ctrl), 128'(exp_issue.ctrl));
        end
        if (r.iv && issue.op1 !== exp_issue.op1) begin
            report_wrong_value("issue.op1", 128'(issue.op1), 128'(exp_issue.op1));
        end
        if (r.iv && issue.op2 !== exp_issue.op2) begin
            report_wrong_value("issue.op2", 128'(issue.op2), 128'(exp_issue.op2));
        end
        if (issue_valid) begin
            n_issued++;
        end
        if (rs_full) begin
            saw_full = 1'b1;
        end
    endtask

    task automatic finish_test(input int test);
        if (test == full_test && !saw_full) begin
            $display("test %0d: rs_full never rose with every slot taken", test);
            n_errors++;
            test_errs++;
        end
        if (n_issued != n_disp) begin
            $display("test %0d: %0d dispatched but %0d issued", test, n_disp, n_issued);
            n_errors++;
            test_errs++;
        end
        $display("test %0d %s: %0d dispatched, %0d issued, %0d errors",
                 test, test_names[test], n_disp, n_issued, test_errs);
        n_tests++;
        test_errs = 0;
        n_disp    = 0;
        n_issued  = 0;
        saw_full  = 1'b0;
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_ctrl  = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        cdb            = '0;
        for (int i = 0; i < rs_depth; i++) begin
            m_busy[i] = 1'b0;
            m_ctrl[i] = '0;
            m_src1[i] = '0;
            m_src2[i] = '0;
        end
        exp_valid = 1'b0;
        exp_issue = '0;
        exp_full  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < tab.size(); r++) begin
            @(posedge clk);
            model_step();
            drive_row(tab[r]);
            @(negedge clk);
            check_outputs(tab[r]);
            if (r > 0 && tab[r].test != tab[r-1].test) begin
                finish_test(tab[r-1].test);
            end
        end
        @(posedge clk);
        model_step();
        drive_row('0);
        @(negedge clk);
        check_outputs('0);
        finish_test(tab[tab.size()-1].test);
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((tab.size() * cycles_per_row + reset_cycles) * clk_period);
        $display("timeout: tests did not complete in %0d cycles",
                 tab.size() * cycles_per_row + reset_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* bench/rs_alu_chk.sv */
`timescale 1ns/1ps

module rs_alu_chk (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        alloc_en,
    input  logic [rs_pkg::slot_w-1:0]   alloc_slot,
    input  logic                        rs_full,
    input  logic                        issue_valid,
    input  logic [rs_pkg::rs_depth-1:0] ready,
    input  logic [rs_pkg::rs_depth-1:0] grant,
    input  logic [rs_pkg::rs_depth-1:0] busy
);

    // lowest ready slot isolated by two's complement
    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant) && grant == (ready & -ready))
        else $error("grant is not the lowest ready slot");

    full_means_all_busy: assert property (@(posedge clk) disable iff (reset)
        rs_full |-> &busy && ($past(rs_full) || $past(alloc_en)))
        else $error("rs_full high without every slot taken by a dispatch");

    // a full station has no free slot, so this also bars dispatch while full
    alloc_into_free_slot: assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> !busy[alloc_slot])
        else $error("dispatch written into a busy slot");

    // checked mid-cycle, away from the edges
    quiet_in_reset: assert property (@(negedge clk) reset |-> !issue_valid)
        else $error("issue_valid high during reset");

endmodule

bind rs_alu_top rs_alu_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .alloc_en    (alloc_en),
    .alloc_slot  (alloc_slot),
    .rs_full     (rs_full),
    .issue_valid (issue_valid),
    .ready       (ready),
    .grant       (grant),
    .busy        (busy)
);

/* src/rs_alu_top.sv */
`timescale 1ns/1ps

module rs_alu_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  rs_pkg::rs_ctrl_t         dispatch_ctrl,
    input  rs_pkg::rs_src_t          dispatch_src1,
    input  rs_pkg::rs_src_t          dispatch_src2,
    input  rs_pkg::cdb_bus_t         cdb,
    output logic                     issue_valid,
    output rs_pkg::rs_issue_t        issue,
    output logic                     rs_full
);
    import rs_pkg::*;

    logic                            alloc_en;
    logic [slot_w-1:0]               alloc_slot;
    rs_src_t                         cap_src1;
    rs_src_t                         cap_src2;
    logic [rs_depth-1:0]             busy;
    logic [rs_depth-1:0]             ready;
    logic [rs_depth-1:0]             grant;
    rs_issue_t [rs_depth-1:0]        entries;

    rs_dispatch u_dispatch (
        .dispatch_valid (dispatch_valid),
        .dispatch_src1  (dispatch_src1),
        .dispatch_src2  (dispatch_src2),
        .cdb            (cdb),
        .busy           (busy),
        .alloc_en       (alloc_en),
        .alloc_slot     (alloc_slot),
        .cap_src1       (cap_src1),
        .cap_src2       (cap_src2),
        .rs_full        (rs_full)
    );

    rs_entry_array u_entry_array (
        .clk            (clk),
        .reset          (reset),
        .alloc_en       (alloc_en),
        .alloc_slot     (alloc_slot),
        .dispatch_ctrl  (dispatch_ctrl),
        .cap_src1       (cap_src1),
        .cap_src2       (cap_src2),
        .cdb            (cdb),
        .grant          (grant),
        .busy           (busy),
        .ready          (ready),
        .entries        (entries)
    );

    rs_issue_select u_issue_select (
        .clk            (clk),
        .reset          (reset),
        .ready          (ready),
        .entries        (entries),
        .grant          (grant),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

endmodule

/* src/rs_issue_select.sv */
`timescale 1ns/1ps

module rs_issue_select (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [rs_pkg::rs_depth-1:0]              ready,
    input  rs_pkg::rs_issue_t [rs_pkg::rs_depth-1:0] entries,
    output logic [rs_pkg::rs_depth-1:0]              grant,
    output logic                                     issue_valid,
    output rs_pkg::rs_issue_t                        issue
);
    import rs_pkg::*;

    logic [slot_w-1:0] pick;
    logic              any_ready;

    assign any_ready = |ready;
    assign pick      = lowest_set(ready); // lowest ready slot index

    always_comb begin
        grant = '0;
        if (any_ready) begin
            grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= any_ready;
        end
    end

    // payload, qualified by issue_valid
    always_ff @(posedge clk) begin
        issue <= entries[pick];
    end

endmodule

/* src/rs_entry_array.sv */
`timescale 1ns/1ps

module rs_entry_array (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       alloc_en,
    input  logic [rs_pkg::slot_w-1:0]                  alloc_slot,
    input  rs_pkg::rs_ctrl_t                           dispatch_ctrl,
    input  rs_pkg::rs_src_t                            cap_src1,
    input  rs_pkg::rs_src_t                            cap_src2,
    input  rs_pkg::cdb_bus_t                           cdb,
    input  logic [rs_pkg::rs_depth-1:0]                grant,
    output logic [rs_pkg::rs_depth-1:0]                busy,
    output logic [rs_pkg::rs_depth-1:0]                ready,
    output rs_pkg::rs_issue_t [rs_pkg::rs_depth-1:0]   entries
);
    import rs_pkg::*;

    rs_ctrl_t [rs_depth-1:0] ctrl_q;
    rs_src_t  [rs_depth-1:0] src1_q;
    rs_src_t  [rs_depth-1:0] src2_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy   <= '0;
            ctrl_q <= '0;
            src1_q <= '0;
            src2_q <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (alloc_en && alloc_slot == slot_w'(i)) begin
                    busy[i]   <= 1'b1;
                    ctrl_q[i] <= dispatch_ctrl;
                    src1_q[i] <= cap_src1; // already merged with bus
                    src2_q[i] <= cap_src2;
                end else begin
                    if (grant[i]) begin
                        busy[i] <= 1'b0; // slot free again next cycle
                    end
                    // wakeup
                    src1_q[i] <= cdb_capture(src1_q[i], cdb);
                    src2_q[i] <= cdb_capture(src2_q[i], cdb);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            ready[i]        = busy[i] && src1_q[i].valid && src2_q[i].valid;
            entries[i].ctrl = ctrl_q[i];
            entries[i].op1  = src1_q[i].data;
            entries[i].op2  = src2_q[i].data;
        end
    end

endmodule

/* src/rs_dispatch.sv */
`timescale 1ns/1ps

module rs_dispatch (
    input  logic                        dispatch_valid,
    input  rs_pkg::rs_src_t             dispatch_src1,
    input  rs_pkg::rs_src_t             dispatch_src2,
    input  rs_pkg::cdb_bus_t            cdb,
    input  logic [rs_pkg::rs_depth-1:0] busy,
    output logic                        alloc_en,
    output logic [rs_pkg::slot_w-1:0]   alloc_slot,
    output rs_pkg::rs_src_t             cap_src1,
    output rs_pkg::rs_src_t             cap_src2,
    output logic                        rs_full
);
    import rs_pkg::*;

    logic [rs_depth-1:0] free_vec;

    assign free_vec = ~busy;

    // full only when every slot holds an instruction
    assign rs_full = &busy;

    // lowest free slot, don't care while full
    assign alloc_slot = lowest_set(free_vec);

    // dispatch while full is dropped
    assign alloc_en = dispatch_valid && !rs_full;

    // a result on the bus this cycle would otherwise be missed
    assign cap_src1 = cdb_capture(dispatch_src1, cdb);
    assign cap_src2 = cdb_capture(dispatch_src2, cdb);

endmodule

/* src/rs_pkg.sv */
package rs_pkg;

    localparam int rs_depth = 16;
    localparam int slot_w   = 4;
    localparam int tag_w    = 8;
    localparam int xlen     = 32;
    localparam int num_cdb  = 2;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // one result broadcast
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } cdb_t;

    typedef cdb_t [num_cdb-1:0] cdb_bus_t; // 0 alu, 1 load

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
        logic             valid;
    } rs_src_t;

    typedef struct packed {
        logic [xlen-1:0]  pc;
        logic [tag_w-1:0] rd;
        alu_op_e          alu_op;
        logic [2:0]       funct3;
        logic [xlen-1:0]  imm;
        logic             src1_is_pc;
        logic             src2_is_imm;
    } rs_ctrl_t;

    typedef struct packed {
        rs_ctrl_t        ctrl;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
    } rs_issue_t;

    function automatic logic [slot_w-1:0] lowest_set(input logic [rs_depth-1:0] vec);
        logic [slot_w-1:0] idx;
        idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin // walk down, last hit wins
            if (vec[i]) idx = slot_w'(i);
        end
        return idx;
    endfunction

    // picks up a matching broadcast for an operand still waiting on its tag
    function automatic rs_src_t cdb_capture(input rs_src_t src, input cdb_bus_t bus);
        rs_src_t res;
        res = src;
        if (!src.valid) begin
            for (int k = num_cdb - 1; k >= 0; k--) begin // alu bus checked last, wins
                if (bus[k].valid && bus[k].tag == src.tag) begin
                    res.valid = 1'b1;
                    res.data  = bus[k].data;
                end
            end
        end
        return res;
    endfunction

endpackage
